// ==== include/qpDecode_consts.svh ====
// Shared constants for the QP decode pipeline, included by RTL and testbench sources
`ifndef QPDECODE_CONSTS_SVH
`define QPDECODE_CONSTS_SVH

// ----------------------------------------------------------------------
// Stream window
// ----------------------------------------------------------------------

// Left-aligned bit window presented with each strobe
`define QP_WINDOW_BITS 16

// Longest Exp-Golomb prefix the decoder supports
`define EG_MAX_ZEROS 7

// ----------------------------------------------------------------------
// Quantisation parameter limits
// ----------------------------------------------------------------------

// Largest legal QP for luma and chroma
`define QP_MAX 51

// Modulus of the QPy wrap
`define QP_RANGE 52

// First QPi value remapped by the chroma table
`define CHROMA_TABLE_START 30

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the QP decode testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f src.f \
	--top-module tbQpDecode \
	-o simQpDecode

# The log decides the result, so a fatal stop must not end the script here
./obj_dir/simQpDecode > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== sim/qpScoreboard.sv ====
// Reference model and result checker for the QP decode pipeline, instantiated by the testbench
`timescale 1ns/100ps
`include "qpDecode_consts.svh"

module qpScoreboard
(
	input  logic clk,
	input  logic reset_n,
	input  logic qpValid,
	input  qpPkg::qpResult_t qp,
	output logic errorFlag
);

	// One expected result and the cycle it is due
	typedef struct
	{
		qpPkg::qpResult_t result;
		int due;
		string testName;
	} expected_t;

	expected_t expQ[$];
	// Rising edges seen so far
	int cycle = 0;
	int modelQpY = 0;
	bit modelSliceActive = 1'b0;

	// Standard chroma table for QPi 30..51
	int chromaTable [0:21] = '{29, 30, 31, 32, 32, 33, 34, 34, 35, 35, 36,
		36, 37, 37, 37, 38, 38, 38, 39, 39, 39, 39};

	initial errorFlag = 1'b0;

	always @(posedge clk)
		cycle <= cycle + 1;

	// ----------------------------------------------------------------------
	// Model arithmetic
	// ----------------------------------------------------------------------

	// Modular wrap into 0..51
	function automatic int wrapQp(input int sum);
		return ((sum % `QP_RANGE) + `QP_RANGE) % `QP_RANGE;
	endfunction

	// Clip of QPi, then the chroma table
	function automatic int chromaQp(input int lumaQp, input int offset);
		int qpi;
		qpi = lumaQp + offset;
		if (qpi < 0)
			qpi = 0;
		else if (qpi > `QP_MAX)
			qpi = `QP_MAX;
		if (qpi < `CHROMA_TABLE_START)
			return qpi;
		return chromaTable[qpi - `CHROMA_TABLE_START];
	endfunction

	function automatic qpPkg::qpResult_t buildResult(input int lumaQp, input int chroma);
		qpPkg::qpResult_t r;
		r.qpY = 6'(lumaQp);
		r.qpC = 6'(chroma);
		r.qpYDiv6 = 4'(lumaQp / 6);
		r.qpCDiv6 = 4'(chroma / 6);
		r.qpYMod6 = 3'(lumaQp % 6);
		r.qpCMod6 = 3'(chroma % 6);
		return r;
	endfunction

	function automatic int pendingCount();
		return expQ.size();
	endfunction

	// ----------------------------------------------------------------------
	// Reporting
	// ----------------------------------------------------------------------

	task automatic compareValue(input string what, input int expected, input int actual);
		if (!errorFlag && expected != actual)
		begin
			$display("[ERROR] %s: expected %0d, actual %0d", what, expected, actual);
			errorFlag = 1'b1;
		end
	endtask

	task automatic reportFailure(input string reason);
		if (!errorFlag)
		begin
			$display("Error at cycle %0d: %s", cycle, reason);
			errorFlag = 1'b1;
		end
	endtask

	// ----------------------------------------------------------------------
	// Strobe intake
	// ----------------------------------------------------------------------

	// Called on the falling edge that drives the strobe
	task automatic issueStrobe(input bit slice, input bit mb, input int delta,
		input int initQp, input int chromaOffset, input string testName);
		expected_t entry;
		// Slice header wins over a coincident mb strobe
		if (slice)
		begin
			modelQpY = wrapQp(26 + initQp + delta);
			modelSliceActive = 1'b1;
		end
		else if (mb && modelSliceActive)
			modelQpY = wrapQp(modelQpY + delta);
		else
			return;
		entry.result = buildResult(modelQpY, chromaQp(modelQpY, chromaOffset));
		// Sampled at the next rise, output four rises later
		entry.due = cycle + 4;
		entry.testName = testName;
		expQ.push_back(entry);
	endtask

	// ----------------------------------------------------------------------
	// Output check
	// ----------------------------------------------------------------------

	// Outputs are stable on the falling edge
	always @(negedge clk)
	begin
		expected_t e;
		if (reset_n && !errorFlag)
		begin
			if (qpValid)
			begin
				if (expQ.size() == 0)
					reportFailure("qpValid pulsed with no QP update pending");
				else
				begin
					e = expQ.pop_front();
					compareValue({e.testName, " latency cycle"}, e.due, cycle);
					compareValue({e.testName, " qpY"}, int'(e.result.qpY), int'(qp.qpY));
					compareValue({e.testName, " qpC"}, int'(e.result.qpC), int'(qp.qpC));
					compareValue({e.testName, " qpYDiv6"}, int'(e.result.qpYDiv6),
						int'(qp.qpYDiv6));
					compareValue({e.testName, " qpCDiv6"}, int'(e.result.qpCDiv6),
						int'(qp.qpCDiv6));
					compareValue({e.testName, " qpYMod6"}, int'(e.result.qpYMod6),
						int'(qp.qpYMod6));
					compareValue({e.testName, " qpCMod6"}, int'(e.result.qpCMod6),
						int'(qp.qpCMod6));
				end
			end
			else if (expQ.size() != 0 && expQ[0].due < cycle)
				reportFailure({"expected qpValid did not arrive in ", expQ[0].testName});
		end
	end

endmodule

// ==== sim/tbQpDecode.sv ====
// Testbench for the QP decode pipeline, random slice and mb QP deltas checked by the scoreboard
`timescale 1ns/100ps
`include "qpDecode_consts.svh"

module tbQpDecode;

	localparam int SLICE_TESTS = 60;
	localparam int MB_RUNS = 20;
	localparam int MB_RUN_LEN = 30;
	localparam int SWEEP_STROBES = 25 * 52;
	localparam int ZERO_TESTS = 8 * 8;
	localparam int STIMULI = 3 + SLICE_TESTS + MB_RUNS * (MB_RUN_LEN + 1) +
		SWEEP_STROBES + ZERO_TESTS;
	// Four cycles per strobe, margin, reset
	localparam int TIMEOUT_CYCLES = 4 * STIMULI + 100 + 4;

	logic clk = 1'b0;
	logic reset_n;
	logic sliceStart;
	logic mbStart;
	logic [`QP_WINDOW_BITS-1:0] bitWindow;
	qpPkg::ppsFields_t pps;
	logic qpValid;
	qpPkg::qpResult_t qp;
	logic [4:0] bitsUsed;
	logic sliceActive;
	logic errorFlag;

	// Model copies of the parameter set
	int initQp;
	int chromaOffset;
	bit expectActive;
	string testName;

	qpDecodeTop i_dut
	(
		.clk(clk),
		.reset_n(reset_n),
		.sliceStart(sliceStart),
		.mbStart(mbStart),
		.bitWindow(bitWindow),
		.pps(pps),
		.qpValid(qpValid),
		.qp(qp),
		.bitsUsed(bitsUsed),
		.sliceActive(sliceActive)
	);

	qpScoreboard u_scoreboard
	(
		.clk(clk),
		.reset_n(reset_n),
		.qpValid(qpValid),
		.qp(qp),
		.errorFlag(errorFlag)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ----------------------------------------------------------------------
	// Exp-Golomb encoding
	// ----------------------------------------------------------------------

	function automatic int randRange(input int lo, input int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	// se(v) mapping, positive values to odd codes
	function automatic int seCode(input int value);
		if (value > 0)
			return 2 * value - 1;
		return -2 * value;
	endfunction

	function automatic int seValue(input int code);
		if (code % 2 == 1)
			return (code + 1) / 2;
		return -(code / 2);
	endfunction

	// Prefix length, one less than the width of code + 1
	function automatic int codeZeros(input int code);
		int zeros;
		zeros = 0;
		while (((code + 1) >> (zeros + 1)) != 0)
			zeros++;
		return zeros;
	endfunction

	// Code left-aligned, random stream bits behind it
	function automatic logic [`QP_WINDOW_BITS-1:0] encodeWindow(input int code);
		int length;
		logic [31:0] pad;
		length = 2 * codeZeros(code) + 1;
		pad = $urandom & ((32'd1 << (`QP_WINDOW_BITS - length)) - 1);
		return 16'(((code + 1) << (`QP_WINDOW_BITS - length)) | pad);
	endfunction

	// ----------------------------------------------------------------------
	// Drive tasks, all on the falling edge
	// ----------------------------------------------------------------------

	task automatic strobe(input bit slice, input bit mb, input int code, input int gap);
		sliceStart = slice;
		mbStart = mb;
		bitWindow = encodeWindow(code);
		u_scoreboard.issueStrobe(slice, mb, seValue(code), initQp, chromaOffset, testName);
		if (slice)
			expectActive = 1'b1;
		@(negedge clk);
		sliceStart = 1'b0;
		mbStart = 1'b0;
		// Code length one cycle after the strobe
		u_scoreboard.compareValue({testName, " bitsUsed"}, 2 * codeZeros(code) + 1,
			int'(bitsUsed));
		u_scoreboard.compareValue({testName, " sliceActive"}, int'(expectActive),
			int'(sliceActive));
		repeat (gap) @(negedge clk);
	endtask

	// Let every queued result come out
	task automatic drain();
		while (u_scoreboard.pendingCount() != 0)
			@(negedge clk);
	endtask

	// New parameter set only with the pipeline empty
	task automatic applyPps(input int init, input int offset);
		drain();
		initQp = init;
		chromaOffset = offset;
		pps.picInitQpMinus26 = 6'(init);
		pps.chromaQpIndexOffset = 5'(offset);
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------

	initial
	begin
		void'($urandom(32'h62a9_f601));
		reset_n = 1'b0;
		sliceStart = 1'b0;
		mbStart = 1'b0;
		bitWindow = '0;
		pps = '0;
		initQp = 0;
		chromaOffset = 0;
		expectActive = 1'b0;
		testName = "reset";
		repeat (4) @(negedge clk);
		reset_n = 1'b1;
		u_scoreboard.compareValue("reset qpValid", 0, int'(qpValid));
		u_scoreboard.compareValue("reset sliceActive", 0, int'(sliceActive));
		u_scoreboard.compareValue("reset qp", 0, int'(qp));

		// mb outside a slice, then both strobes at once
		testName = "strobeOrder";
		strobe(1'b0, 1'b1, seCode(randRange(-26, 25)), 2);
		strobe(1'b1, 1'b1, seCode(randRange(1, 25)), 0);
		// Again with the slice open, an mb win would add onto the nonzero QPy offset
		strobe(1'b1, 1'b1, seCode(randRange(-26, 25)), 0);

		testName = "sliceDelta";
		for (int i = 0; i < SLICE_TESTS; i++)
		begin
			applyPps(randRange(-26, 25), randRange(-12, 12));
			strobe(1'b1, 1'b0, seCode(randRange(-60, 60)), 0);
		end

		// Gap of zero gives back-to-back strobes
		testName = "mbRun";
		for (int r = 0; r < MB_RUNS; r++)
		begin
			applyPps(randRange(-26, 25), randRange(-12, 12));
			strobe(1'b1, 1'b0, seCode(randRange(-26, 25)), $urandom % 3);
			for (int k = 0; k < MB_RUN_LEN; k++)
				strobe(1'b0, 1'b1, seCode(randRange(-26, 25)), $urandom % 3);
		end

		// QPy 0..51 for every chroma offset
		testName = "chromaSweep";
		for (int off = -12; off <= 12; off++)
		begin
			applyPps(0, off);
			for (int y = 0; y <= `QP_MAX; y++)
				strobe(1'b1, 1'b0, seCode(y - 26), $urandom % 2);
		end

		// Codes with 0..7 leading zeros
		testName = "codeLength";
		for (int z = 0; z <= `EG_MAX_ZEROS; z++)
		begin
			for (int n = 0; n < 8; n++)
				strobe(1'b0, 1'b1, (1 << z) - 1 + int'($urandom % (1 << z)), $urandom % 3);
		end

		drain();
		// Quiet cycles catch a stray qpValid
		repeat (8) @(negedge clk);
		if (errorFlag)
		begin
			$display("FAIL: see errors above");
			$fatal(1, "Run ended with errors");
		end
		else
		begin
			$display("PASS: all tests");
			$finish;
		end
	end

	// First failed check ends the run
	always @(posedge errorFlag)
	begin
		$display("FAIL: see errors above");
		$fatal(1, "Stopping at the first error");
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * 4);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("FAIL: see errors above");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== src.f ====
+incdir+include
src/syntaxPkg.sv
src/qpPkg.sv
src/expGolombDecoder.sv
src/syntaxSequencer.sv
src/qpDecoding.sv
src/qpScaleSplit.sv
src/qpDecodeTop.sv
sim/qpScoreboard.sv
sim/tbQpDecode.sv

// ==== src/expGolombDecoder.sv ====
// Exp-Golomb decoder, registers the ue/se value and code length of one strobed window
`timescale 1ns/100ps
`include "qpDecode_consts.svh"

module expGolombDecoder
(
	input  logic clk,
	input  logic reset_n,
	input  logic sample,
	input  logic [`QP_WINDOW_BITS-1:0] bitWindow,
	output syntaxPkg::egResult_t result
);

	// Prefix length, 16 when the window is all zeros
	logic [4:0] zeroCount;
	// Right shift that leaves prefix, marker and suffix in the low bits
	logic [4:0] shiftAmt;
	logic [`QP_WINDOW_BITS-1:0] codeNum;
	syntaxPkg::egValue_u nextValue;

	// ----------------------------------------------------------------------
	// Leading-zero count
	// ----------------------------------------------------------------------

	always_comb
	begin
		zeroCount = 5'd`QP_WINDOW_BITS;
		// Scan upward, the highest set bit wins
		for (int i = 0; i < `QP_WINDOW_BITS; i++)
		begin
			if (bitWindow[i])
				zeroCount = 5'(`QP_WINDOW_BITS - 1 - i);
		end
	end

	// ----------------------------------------------------------------------
	// Code number and signed mapping
	// ----------------------------------------------------------------------

	// Marker bit sits at position 15 - zeros
	assign shiftAmt = 5'(`QP_WINDOW_BITS - 1) - {zeroCount[3:0], 1'b0};

	// Marker plus suffix equals codeNum + 1
	assign codeNum = (bitWindow >> shiftAmt) - 16'd1;

	always_comb
	begin
		// Odd codes positive, even codes negative
		if (codeNum[0])
			nextValue.signedValue = signed'((codeNum + 16'd1) >> 1);
		else
			nextValue.signedValue = -signed'(codeNum >> 1);
	end

	// ----------------------------------------------------------------------
	// Result register
	// ----------------------------------------------------------------------

	// Loaded only on strobe cycles
	always_ff @(posedge clk)
	begin
		if (sample)
		begin
			result.value <= nextValue;
			result.bitsUsed <= {zeroCount[3:0], 1'b1};
		end
	end

	// Longer prefixes are outside the supported stream
	assert property (@(posedge clk) disable iff (!reset_n)
		sample |-> zeroCount <= `EG_MAX_ZEROS);

endmodule

// ==== src/qpDecodeTop.sv ====
// Top level of the QP decode pipeline, strobe to qpValid in four cycles
`timescale 1ns/100ps
`include "qpDecode_consts.svh"

module qpDecodeTop
(
	input  logic clk,
	input  logic reset_n,
	input  logic sliceStart,
	input  logic mbStart,
	input  logic [`QP_WINDOW_BITS-1:0] bitWindow,
	input  qpPkg::ppsFields_t pps,
	output logic qpValid,
	output qpPkg::qpResult_t qp,
	output logic [4:0] bitsUsed,
	output logic sliceActive
);

	syntaxPkg::egResult_t egResult;
	syntaxPkg::qpStage_e stage;
	logic stageValid;
	logic [5:0] qpY;
	logic [5:0] qpC;

	// Code length straight from the decoder register
	assign bitsUsed = egResult.bitsUsed;

	// Decodes on either strobe
	expGolombDecoder u_expGolombDecoder
	(
		.clk(clk),
		.reset_n(reset_n),
		.sample(sliceStart || mbStart),
		.bitWindow(bitWindow),
		.result(egResult)
	);

	syntaxSequencer u_syntaxSequencer
	(
		.clk(clk),
		.reset_n(reset_n),
		.sliceStart(sliceStart),
		.mbStart(mbStart),
		.stage(stage),
		.stageValid(stageValid),
		.sliceActive(sliceActive)
	);

	qpDecoding u_qpDecoding
	(
		.clk(clk),
		.reset_n(reset_n),
		.stage(stage),
		.delta(egResult),
		.pps(pps),
		.qpY(qpY),
		.qpC(qpC)
	);

	qpScaleSplit u_qpScaleSplit
	(
		.clk(clk),
		.reset_n(reset_n),
		.stageValid(stageValid),
		.qpY(qpY),
		.qpC(qpC),
		.qp(qp),
		.qpValid(qpValid)
	);

endmodule

// ==== src/qpDecoding.sv ====
// Luma QP accumulation and chroma QP mapping for slice and macroblock QP deltas
`timescale 1ns/100ps
`include "qpDecode_consts.svh"

module qpDecoding
(
	input  logic clk,
	input  logic reset_n,
	input  syntaxPkg::qpStage_e stage,
	input  syntaxPkg::egResult_t delta,
	input  qpPkg::ppsFields_t pps,
	output logic [5:0] qpY,
	output logic [5:0] qpC
);

	// Delta narrowed, supported codes stay within +-127
	logic signed [10:0] deltaExt;
	logic signed [10:0] sliceSum;
	logic signed [10:0] mbSum;
	// Intermediate chroma QP before and after the clip
	logic signed [7:0] qpiSum;
	logic [5:0] qpi;

	// Brings a sum back into 0..51
	function automatic logic [5:0] wrapQp(input logic signed [10:0] sum);
		logic signed [10:0] acc;
		acc = sum;
		// Four steps cover -133..184
		for (int i = 0; i < 4; i++)
		begin
			if (acc < 0)
				acc = acc + 11'(`QP_RANGE);
			else if (acc > `QP_MAX)
				acc = acc - 11'(`QP_RANGE);
		end
		return acc[5:0];
	endfunction

	// ----------------------------------------------------------------------
	// Luma QP
	// ----------------------------------------------------------------------

	assign deltaExt = $signed(delta.value.signedValue[10:0]);

	// 26 + pic_init_qp_minus26 + slice_qp_delta
	assign sliceSum = 11'sd26 + {{5{pps.picInitQpMinus26[5]}}, pps.picInitQpMinus26} + deltaExt;

	// Previous QPy + mb_qp_delta
	assign mbSum = $signed({5'd0, qpY}) + deltaExt;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			qpY <= 6'd0;
		else
		begin
			case (stage)
				syntaxPkg::sliceQpDelta: qpY <= wrapQp(sliceSum);
				syntaxPkg::mbQpDelta: qpY <= wrapQp(mbSum);
				default: qpY <= qpY;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Chroma QP
	// ----------------------------------------------------------------------

	assign qpiSum = $signed({2'b00, qpY}) +
		{{3{pps.chromaQpIndexOffset[4]}}, pps.chromaQpIndexOffset};

	// Clip to the legal QP range
	always_comb
	begin
		if (qpiSum < 0)
			qpi = 6'd0;
		else if (qpiSum > `QP_MAX)
			qpi = 6'(`QP_MAX);
		else
			qpi = qpiSum[5:0];
	end

	// Table lookup, passes through below the table start
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			qpC <= 6'd0;
		else if (qpi < `CHROMA_TABLE_START)
			qpC <= qpi;
		else
		begin
			case (qpi)
				6'd30: qpC <= 6'd29;
				6'd31: qpC <= 6'd30;
				6'd32: qpC <= 6'd31;
				6'd33, 6'd34: qpC <= 6'd32;
				6'd35: qpC <= 6'd33;
				6'd36, 6'd37: qpC <= 6'd34;
				6'd38, 6'd39: qpC <= 6'd35;
				6'd40, 6'd41: qpC <= 6'd36;
				6'd42, 6'd43, 6'd44: qpC <= 6'd37;
				6'd45, 6'd46, 6'd47: qpC <= 6'd38;
				// 48..51
				default: qpC <= 6'd39;
			endcase
		end
	end

	// Any ordered update leaves QPy in range
	assert property (@(posedge clk) disable iff (!reset_n)
		stage != syntaxPkg::idle |=> qpY <= `QP_MAX);

endmodule

// ==== src/qpPkg.sv ====
// Picture-level inputs and QP output types of the QP decode pipeline

package qpPkg;

	// ------------------------------------------------------------------
	// Parameter-set fields
	// ------------------------------------------------------------------

	// Static over a slice
	typedef struct packed
	{
		// Slice QP base, offset from 26
		logic signed [5:0] picInitQpMinus26;
		// Chroma offset, -12..12
		logic signed [4:0] chromaQpIndexOffset;
	} ppsFields_t;

	// ------------------------------------------------------------------
	// QP result
	// ------------------------------------------------------------------

	// Both QPs plus the split used by dequantisation
	typedef struct packed
	{
		// Luma QP, 0..51
		logic [5:0] qpY;
		// Chroma QP, 0..39
		logic [5:0] qpC;
		// Quotient by 6, up to 8
		logic [3:0] qpYDiv6;
		logic [3:0] qpCDiv6;
		// Remainder by 6
		logic [2:0] qpYMod6;
		logic [2:0] qpCMod6;
	} qpResult_t;

endpackage

// ==== src/qpScaleSplit.sv ====
// Output stage, registers both QPs with their div-6 and mod-6 parts and the valid pulse
`timescale 1ns/100ps
`include "qpDecode_consts.svh"

module qpScaleSplit
(
	input  logic clk,
	input  logic reset_n,
	input  logic stageValid,
	input  logic [5:0] qpY,
	input  logic [5:0] qpC,
	output qpPkg::qpResult_t qp,
	output logic qpValid
);

	// Luma QP one cycle late, in step with the chroma register
	logic [5:0] qpYLate;
	// Quotient and remainder of each QP
	logic [6:0] splitY;
	logic [6:0] splitC;

	// Quotient from a ladder of multiples of 6, remainder by subtraction
	function automatic logic [6:0] splitSix(input logic [5:0] value);
		logic [3:0] quot;
		logic [5:0] rem;
		quot = 4'd0;
		for (int i = 1; i <= `QP_MAX / 6; i++)
		begin
			if (value >= 6 * i)
				quot = 4'(i);
		end
		rem = value - 6'(6 * quot);
		return {quot, rem[2:0]};
	endfunction

	assign splitY = splitSix(qpYLate);
	assign splitC = splitSix(qpC);

	// ----------------------------------------------------------------------
	// Output register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			qp <= '0;
			qpValid <= 1'b0;
			qpYLate <= 6'd0;
		end
		else
		begin
			qpValid <= stageValid;
			// Same update that produced the current qpC
			qpYLate <= qpY;
			// Holds the last result between updates
			if (stageValid)
			begin
				qp.qpY <= qpYLate;
				qp.qpC <= qpC;
				qp.qpYDiv6 <= splitY[6:3];
				qp.qpCDiv6 <= splitC[6:3];
				qp.qpYMod6 <= splitY[2:0];
				qp.qpCMod6 <= splitC[2:0];
			end
		end
	end

endmodule

// ==== src/syntaxPkg.sv ====
// Parse-side types shared by the Exp-Golomb decoder, the sequencer and QP decoding
`include "qpDecode_consts.svh"

package syntaxPkg;

	// ------------------------------------------------------------------
	// Exp-Golomb decoded value
	// ------------------------------------------------------------------

	// One decoded word, viewed as ue(v) or se(v)
	typedef union packed
	{
		// Unsigned code number
		logic [`QP_WINDOW_BITS-1:0] codeNum;
		// Signed mapping of the code number
		logic signed [`QP_WINDOW_BITS-1:0] signedValue;
	} egValue_u;

	// Decoded value plus code length
	typedef struct packed
	{
		egValue_u value;
		// 2 * zeros + 1, at most 15 for supported codes
		logic [4:0] bitsUsed;
	} egResult_t;

	// ------------------------------------------------------------------
	// Parse stage
	// ------------------------------------------------------------------

	// Kind of QP update ordered by the sequencer
	typedef enum logic [1:0]
	{
		idle = 2'd0,
		sliceQpDelta = 2'd1,
		mbQpDelta = 2'd2
	} qpStage_e;

endpackage

// ==== src/syntaxSequencer.sv ====
// Parse-state control, turns slice and macroblock strobes into staged QP update orders
`timescale 1ns/100ps

module syntaxSequencer
(
	input  logic clk,
	input  logic reset_n,
	input  logic sliceStart,
	input  logic mbStart,
	output syntaxPkg::qpStage_e stage,
	output logic stageValid,
	output logic sliceActive
);

	// Stage chosen from this cycle's strobes
	syntaxPkg::qpStage_e nextStage;
	// Token one stage behind the stage register
	logic validPipe;

	// ----------------------------------------------------------------------
	// Strobe priority
	// ----------------------------------------------------------------------

	always_comb
	begin
		// Slice header wins over a coincident mb strobe
		if (sliceStart)
			nextStage = syntaxPkg::sliceQpDelta;
		// mb_qp_delta only counts inside a slice
		else if (mbStart && sliceActive)
			nextStage = syntaxPkg::mbQpDelta;
		else
			nextStage = syntaxPkg::idle;
	end

	// ----------------------------------------------------------------------
	// Stage and token registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			stage <= syntaxPkg::idle;
			sliceActive <= 1'b0;
			validPipe <= 1'b0;
			stageValid <= 1'b0;
		end
		else
		begin
			// Aligned with the decoder's result register
			stage <= nextStage;
			// Sticky once the first slice header is seen
			if (sliceStart)
				sliceActive <= 1'b1;
			// Follows the QPy update, then the QPc register
			validPipe <= (stage != syntaxPkg::idle);
			stageValid <= validPipe;
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	// An mb update needs an open slice at its strobe
	assert property (@(posedge clk) disable iff (!reset_n)
		stage == syntaxPkg::mbQpDelta |-> $past(sliceActive));

	// Every token traces back to an ordered update
	assert property (@(posedge clk) disable iff (!reset_n)
		stageValid |-> $past(stage != syntaxPkg::idle, 2));

endmodule
